// File: verilog/mem_pkg.sv
package mem_pkg;

  // byte address and data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // axi size code: 0 byte, 1 half, 2 word
  typedef logic [2:0]  size_t;

  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // 256 bytes of ram at address 0
  localparam int unsigned MEM_WORDS = 64;

  // cycles from ar handshake to rvalid, must be 2 or more
  localparam int unsigned MEM_LAT = 2;

  localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

// File: verilog/mem_arb.sv
`timescale 1ns/1ns
module mem_arb (
  input  logic           clk,
  input  logic           rstn,
  input  logic           ifu_arvalid,
  output logic           ifu_arready,
  input  mem_pkg::addr_t ifu_araddr,
  output logic           ifu_rvalid,
  input  logic           ifu_rready,
  output mem_pkg::data_t ifu_rdata,
  output mem_pkg::resp_t ifu_rresp,
  input  logic           lsu_arvalid,
  output logic           lsu_arready,
  input  mem_pkg::addr_t lsu_araddr,
  input  mem_pkg::size_t lsu_arsize,
  output logic           lsu_rvalid,
  input  logic           lsu_rready,
  output mem_pkg::data_t lsu_rdata,
  output mem_pkg::resp_t lsu_rresp,
  output logic           ram_arvalid,
  input  logic           ram_arready,
  output mem_pkg::addr_t ram_araddr,
  output mem_pkg::size_t ram_arsize,
  input  logic           ram_rvalid,
  output logic           ram_rready,
  input  mem_pkg::data_t ram_rdata,
  input  mem_pkg::resp_t ram_rresp
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_PARK   // lsu read in flight with the ifu address in the slot
  } state_t;

  state_t state;
  logic   grant_lsu;  // who gets the next r beat
  logic   slot_full;
  addr_t  slot_addr;
  logic   accept;
  logic   sel_lsu;
  logic   tie;
  logic   ram_ar_fire;
  logic   ram_r_fire;

  // new requests only while idle with nothing parked
  assign accept  = (state == ST_IDLE) & ~slot_full;
  assign sel_lsu = lsu_arvalid;  // load wins on a tie
  assign tie     = accept & ifu_arvalid & lsu_arvalid;

  assign ifu_arready = accept & ram_arready;
  assign lsu_arready = accept & ram_arready;

  assign ram_arvalid = (state == ST_IDLE) & (slot_full | ifu_arvalid | lsu_arvalid);

  always_comb begin
    if (slot_full) begin
      ram_araddr = slot_addr;
      ram_arsize = 3'd2;  // fetches are always word reads
    end else if (sel_lsu) begin
      ram_araddr = lsu_araddr;
      ram_arsize = lsu_arsize;
    end else begin
      ram_araddr = ifu_araddr;
      ram_arsize = 3'd2;
    end
  end

  assign ram_ar_fire = ram_arvalid & ram_arready;
  assign ram_r_fire  = ram_rvalid & ram_rready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      state     <= ST_IDLE;
      grant_lsu <= 1'b0;
      slot_full <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ram_ar_fire) begin
            grant_lsu <= ~slot_full & sel_lsu;
            slot_full <= 1'b0;  // a parked read drains here
            state     <= tie ? ST_PARK : ST_BUSY;
          end
        end
        ST_BUSY: if (ram_r_fire) state <= ST_IDLE;
        ST_PARK: begin
          if (ram_r_fire) begin
            slot_full <= 1'b1;  // held fetch issues next cycle
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tie & ram_arready) slot_addr <= ifu_araddr;
  end

  // response goes back to the last granted master
  assign ifu_rvalid = ram_rvalid & ~grant_lsu;
  assign lsu_rvalid = ram_rvalid & grant_lsu;
  assign ram_rready = grant_lsu ? lsu_rready : ifu_rready;

  assign ifu_rdata = ram_rdata;
  assign lsu_rdata = ram_rdata;
  assign ifu_rresp = ram_rresp;
  assign lsu_rresp = ram_rresp;

endmodule

// File: verilog/ifu_fetch.sv
`timescale 1ns/1ns
module ifu_fetch (
  input  logic           clk,
  input  logic           rstn,
  input  logic           redirect_valid,
  input  mem_pkg::addr_t redirect_pc,
  output logic           instr_valid,
  output mem_pkg::addr_t instr_pc,
  output mem_pkg::data_t instr,
  output logic           instr_err,
  input  logic           instr_ready,
  output logic           ifu_arvalid,
  input  logic           ifu_arready,
  output mem_pkg::addr_t ifu_araddr,
  input  logic           ifu_rvalid,
  output logic           ifu_rready,
  input  mem_pkg::data_t ifu_rdata,
  input  mem_pkg::resp_t ifu_rresp
);
  import mem_pkg::*;

  addr_t pc;        // next address to fetch
  addr_t fetch_pc;  // address of the read in flight
  logic  wait_r;
  logic  drop;      // in-flight result is stale
  logic  ar_fire;
  logic  r_fire;
  logic  out_fire;
  logic  start;

  assign ar_fire  = ifu_arvalid & ifu_arready;
  assign r_fire   = ifu_rvalid & ifu_rready;
  assign out_fire = instr_valid & instr_ready;

  // one read at a time, and only once the slot is free
  assign start = ~ifu_arvalid & ~wait_r & ~redirect_valid & (~instr_valid | instr_ready);

  assign ifu_araddr = fetch_pc;
  assign ifu_rready = drop | ~instr_valid;

  always_ff @(posedge clk) begin
    if (rstn) begin
      pc          <= RESET_PC;
      ifu_arvalid <= 1'b0;
      wait_r      <= 1'b0;
      drop        <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      if (start) begin
        ifu_arvalid <= 1'b1;
        pc          <= pc + 32'd4;
      end else if (ar_fire) begin
        ifu_arvalid <= 1'b0;
        wait_r      <= 1'b1;
      end
      if (r_fire) wait_r <= 1'b0;

      if (redirect_valid) begin
        pc   <= redirect_pc;
        drop <= ifu_arvalid | (wait_r & ~r_fire);  // still owe a response
      end else if (r_fire) begin
        drop <= 1'b0;
      end

      if (r_fire & ~drop & ~redirect_valid) begin
        instr_valid <= 1'b1;
      end else if (out_fire | redirect_valid) begin
        instr_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) fetch_pc <= pc;
    if (r_fire) begin
      instr_pc  <= fetch_pc;
      instr     <= ifu_rdata;
      instr_err <= (ifu_rresp != RESP_OKAY);
    end
  end

endmodule

// File: verilog/lsu_load.sv
`timescale 1ns/1ns
module lsu_load (
  input  logic           clk,
  input  logic           rstn,
  input  logic           load_valid,
  input  mem_pkg::addr_t load_addr,
  input  mem_pkg::size_t load_size,
  input  logic           load_signed,
  output logic           load_ready,
  output logic           res_valid,
  output mem_pkg::data_t res_data,
  output logic           res_err,
  output logic           lsu_arvalid,
  input  logic           lsu_arready,
  output mem_pkg::addr_t lsu_araddr,
  output mem_pkg::size_t lsu_arsize,
  input  logic           lsu_rvalid,
  output logic           lsu_rready,
  input  mem_pkg::data_t lsu_rdata,
  input  mem_pkg::resp_t lsu_rresp
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_RESP
  } state_t;

  state_t state;
  addr_t  addr_q;
  size_t  size_q;
  logic   signed_q;
  data_t  shifted;
  data_t  ext;
  logic   r_fire;

  assign load_ready  = (state == ST_IDLE);
  assign lsu_arvalid = (state == ST_ADDR);
  assign lsu_araddr  = addr_q;
  assign lsu_arsize  = size_q;
  assign lsu_rready  = (state == ST_RESP);
  assign r_fire      = lsu_rvalid & lsu_rready;

  // bring the addressed byte down to bit 0
  assign shifted = lsu_rdata >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (size_q)
      3'd0:    ext = {{24{signed_q & shifted[7]}}, shifted[7:0]};
      3'd1:    ext = {{16{signed_q & shifted[15]}}, shifted[15:0]};
      default: ext = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state     <= ST_IDLE;
      res_valid <= 1'b0;
    end else begin
      res_valid <= 1'b0;  // single-cycle pulse
      case (state)
        ST_IDLE: if (load_valid) state <= ST_ADDR;
        ST_ADDR: if (lsu_arready) state <= ST_RESP;
        ST_RESP: begin
          if (r_fire) begin
            res_valid <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load_valid & load_ready) begin
      addr_q   <= load_addr;
      size_q   <= load_size;
      signed_q <= load_signed;
    end
    if (r_fire) begin
      res_data <= ext;  // error beats carry 0
      res_err  <= (lsu_rresp != RESP_OKAY);
    end
  end

endmodule

// File: verilog/sram_rd.sv
`timescale 1ns/1ns
module sram_rd (
  input  logic           clk,
  input  logic           rstn,
  input  logic           ram_arvalid,
  output logic           ram_arready,
  input  mem_pkg::addr_t ram_araddr,
  input  mem_pkg::size_t ram_arsize,
  output logic           ram_rvalid,
  input  logic           ram_rready,
  output mem_pkg::data_t ram_rdata,
  output mem_pkg::resp_t ram_rresp
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } state_t;

  state_t     state;
  logic [3:0] cnt;
  data_t      mem [0:MEM_WORDS-1];
  logic       in_range;
  data_t      rd_word;
  data_t      lane_mask;

  initial begin
    $readmemh("mem_init.hex", mem);
  end

  assign in_range = (ram_araddr < addr_t'(4 * MEM_WORDS));
  assign rd_word  = mem[ram_araddr[$clog2(MEM_WORDS)+1:2]];

  // narrow reads only drive their own byte lanes
  always_comb begin
    case (ram_arsize)
      3'd0:    lane_mask = 32'h0000_00ff << {ram_araddr[1:0], 3'b000};
      3'd1:    lane_mask = 32'h0000_ffff << {ram_araddr[1:0], 3'b000};
      default: lane_mask = '1;
    endcase
  end

  assign ram_arready = (state == ST_IDLE);
  assign ram_rvalid  = (state == ST_RESP);

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ram_arvalid) begin
            cnt   <= 4'(MEM_LAT - 1);
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (cnt == 4'd1) state <= ST_RESP;
          else cnt <= cnt - 4'd1;
        end
        ST_RESP: if (ram_rready) state <= ST_IDLE;  // hold under back-pressure
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ram_arvalid & ram_arready) begin
      ram_rdata <= in_range ? (rd_word & lane_mask) : '0;
      ram_rresp <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// File: verilog/mem_sys.sv
`timescale 1ns/1ns
module mem_sys (
  input  logic           clk,
  input  logic           rstn,
  input  logic           redirect_valid,
  input  mem_pkg::addr_t redirect_pc,
  output logic           instr_valid,
  output mem_pkg::addr_t instr_pc,
  output mem_pkg::data_t instr,
  output logic           instr_err,
  input  logic           instr_ready,
  input  logic           load_valid,
  input  mem_pkg::addr_t load_addr,
  input  mem_pkg::size_t load_size,
  input  logic           load_signed,
  output logic           load_ready,
  output logic           res_valid,
  output mem_pkg::data_t res_data,
  output logic           res_err
);
  import mem_pkg::*;

  // fetch side
  logic  ifu_arvalid;
  logic  ifu_arready;
  addr_t ifu_araddr;
  logic  ifu_rvalid;
  logic  ifu_rready;
  data_t ifu_rdata;
  resp_t ifu_rresp;

  // load side
  logic  lsu_arvalid;
  logic  lsu_arready;
  addr_t lsu_araddr;
  size_t lsu_arsize;
  logic  lsu_rvalid;
  logic  lsu_rready;
  data_t lsu_rdata;
  resp_t lsu_rresp;

  // memory port
  logic  ram_arvalid;
  logic  ram_arready;
  addr_t ram_araddr;
  size_t ram_arsize;
  logic  ram_rvalid;
  logic  ram_rready;
  data_t ram_rdata;
  resp_t ram_rresp;

  ifu_fetch ifu_fetch_inst (
    .clk, .rstn,
    .redirect_valid, .redirect_pc,
    .instr_valid, .instr_pc, .instr, .instr_err, .instr_ready,
    .ifu_arvalid, .ifu_arready, .ifu_araddr,
    .ifu_rvalid, .ifu_rready, .ifu_rdata, .ifu_rresp
  );

  lsu_load lsu_load_inst (
    .clk, .rstn,
    .load_valid, .load_addr, .load_size, .load_signed, .load_ready,
    .res_valid, .res_data, .res_err,
    .lsu_arvalid, .lsu_arready, .lsu_araddr, .lsu_arsize,
    .lsu_rvalid, .lsu_rready, .lsu_rdata, .lsu_rresp
  );

  mem_arb mem_arb_inst (
    .clk, .rstn,
    .ifu_arvalid, .ifu_arready, .ifu_araddr,
    .ifu_rvalid, .ifu_rready, .ifu_rdata, .ifu_rresp,
    .lsu_arvalid, .lsu_arready, .lsu_araddr, .lsu_arsize,
    .lsu_rvalid, .lsu_rready, .lsu_rdata, .lsu_rresp,
    .ram_arvalid, .ram_arready, .ram_araddr, .ram_arsize,
    .ram_rvalid, .ram_rready, .ram_rdata, .ram_rresp
  );

  sram_rd sram_rd_inst (
    .clk, .rstn,
    .ram_arvalid, .ram_arready, .ram_araddr, .ram_arsize,
    .ram_rvalid, .ram_rready, .ram_rdata, .ram_rresp
  );

endmodule

// File: tb/tb_mem_sys.sv
`timescale 1ns/1ns
module tb_mem_sys;
  import mem_pkg::*;

  localparam int N_SEQ     = 16;
  localparam int N_REDIR   = 4;   // redirects with four fetches after each
  localparam int N_LOAD    = 24;
  localparam int N_CONT    = 16;
  localparam int N_BP      = 16;
  localparam int MAX_STALL = 6;
  localparam int N_ERR     = 4;
  // fetches, loads, dropped reads after redirects and the odd extra fetch
  localparam int N_READS = N_SEQ + N_REDIR * 5 + N_LOAD + 2 * N_CONT + N_BP + 2 * N_ERR + 8;
  localparam int LIMIT   = (N_READS + N_BP * MAX_STALL) * (int'(MEM_LAT) + 6) + 300;

  logic  clk;
  logic  rstn;
  logic  redirect_valid;
  addr_t redirect_pc;
  logic  instr_valid;
  addr_t instr_pc;
  data_t instr;
  logic  instr_err;
  logic  instr_ready;
  logic  load_valid;
  addr_t load_addr;
  size_t load_size;
  logic  load_signed;
  logic  load_ready;
  logic  res_valid;
  data_t res_data;
  logic  res_err;

  data_t ref_mem [0:MEM_WORDS-1];
  addr_t exp_pc;      // pc of the next instruction the core should see
  data_t exp_instr;
  logic  exp_ierr;
  addr_t ld_addr;
  size_t ld_size;
  logic  ld_signed;
  logic  ld_pending;
  data_t exp_res;
  logic  exp_rerr;
  logic  exp_ready;
  logic  stall_q;
  int    fetch_cnt;
  int    load_cnt;
  int    cycle_cnt;
  int    err_cnt  = 0;
  int    err_base = 0;
  int    test_cnt = 0;

  mem_sys mem_sys_inst (
    .clk, .rstn,
    .redirect_valid, .redirect_pc,
    .instr_valid, .instr_pc, .instr, .instr_err, .instr_ready,
    .load_valid, .load_addr, .load_size, .load_signed, .load_ready,
    .res_valid, .res_data, .res_err
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reference memory reads zero outside the ram
  function automatic data_t mem_word(addr_t a);
    if (a >= addr_t'(4 * MEM_WORDS)) return '0;
    return ref_mem[a[7:2]];
  endfunction

  function automatic data_t load_model(addr_t a, size_t sz, logic sgn);
    data_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = mem_word(a);
    b = w[8 * a[1:0] +: 8];
    h = w[16 * a[1] +: 16];  // halves are aligned
    case (sz)
      3'd0:    return sgn ? data_t'($signed(b)) : data_t'(b);
      3'd1:    return sgn ? data_t'($signed(h)) : data_t'(h);
      default: return w;
    endcase
  endfunction

  assign exp_instr = mem_word(exp_pc);
  assign exp_ierr  = (exp_pc >= addr_t'(4 * MEM_WORDS));
  assign exp_res   = load_model(ld_addr, ld_size, ld_signed);
  assign exp_rerr  = (ld_addr >= addr_t'(4 * MEM_WORDS));
  assign exp_ready = !ld_pending || res_valid;  // idle again once the result is out

  always @(posedge clk) begin
    if (rstn) begin
      exp_pc     <= RESET_PC;
      fetch_cnt  <= 0;
      load_cnt   <= 0;
      ld_pending <= 1'b0;
    end else begin
      if (redirect_valid) exp_pc <= redirect_pc;
      else if (instr_valid && instr_ready) exp_pc <= exp_pc + 32'd4;
      if (instr_valid && instr_ready) fetch_cnt <= fetch_cnt + 1;
      if (res_valid) load_cnt <= load_cnt + 1;
      if (load_valid && load_ready) begin
        ld_addr    <= load_addr;
        ld_size    <= load_size;
        ld_signed  <= load_signed;
        ld_pending <= 1'b1;
      end else if (res_valid) begin
        ld_pending <= 1'b0;
      end
    end
    stall_q <= !rstn && instr_valid && !instr_ready && !redirect_valid;
  end

  // checks sample on the falling edge
  pc_check: assert property (@(negedge clk) disable iff (rstn)
      instr_valid |-> instr_pc == exp_pc)
    else begin
      $display("[FAIL] %0t ns instr_pc expected %h got %h", $time, exp_pc, instr_pc);
      err_cnt++;
    end
  instr_check: assert property (@(negedge clk) disable iff (rstn)
      instr_valid |-> instr == exp_instr)
    else begin
      $display("[FAIL] %0t ns instr expected %h got %h", $time, exp_instr, instr);
      err_cnt++;
    end
  ierr_check: assert property (@(negedge clk) disable iff (rstn)
      instr_valid |-> instr_err == exp_ierr)
    else begin
      $display("[FAIL] %0t ns instr_err expected %b got %b", $time, exp_ierr, instr_err);
      err_cnt++;
    end
  hold_check: assert property (@(negedge clk) disable iff (rstn)
      stall_q |-> instr_valid)
    else begin
      $display("%0t ns: instr_valid dropped while instr_ready was low", $time);
      err_cnt++;
    end
  pend_check: assert property (@(negedge clk) disable iff (rstn)
      res_valid |-> ld_pending)
    else begin
      $display("%0t ns: res_valid with no load outstanding", $time);
      err_cnt++;
    end
  ready_check: assert property (@(negedge clk) disable iff (rstn)
      load_ready == exp_ready)
    else begin
      $display("[FAIL] %0t ns load_ready expected %b got %b", $time, exp_ready, load_ready);
      err_cnt++;
    end
  res_check: assert property (@(negedge clk) disable iff (rstn)
      res_valid |-> res_data == exp_res)
    else begin
      $display("[FAIL] %0t ns res_data expected %h got %h", $time, exp_res, res_data);
      err_cnt++;
    end
  rerr_check: assert property (@(negedge clk) disable iff (rstn)
      res_valid |-> res_err == exp_rerr)
    else begin
      $display("[FAIL] %0t ns res_err expected %b got %b", $time, exp_rerr, res_err);
      err_cnt++;
    end

  task automatic redirect_to(addr_t pc);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= pc;
    @(posedge clk);
    redirect_valid <= 1'b0;
  endtask

  task automatic wait_fetches(int n);
    int target;
    target = fetch_cnt + n;
    while (fetch_cnt < target) @(posedge clk);
  endtask

  task automatic do_load(addr_t a, size_t sz, logic sgn);
    @(posedge clk);
    load_valid  <= 1'b1;
    load_addr   <= a;
    load_size   <= sz;
    load_signed <= sgn;
    do @(posedge clk); while (!load_ready);
    load_valid <= 1'b0;
    do @(posedge clk); while (!res_valid);
  endtask

  // naturally aligned load above the ram when high is set
  task automatic random_load(logic high);
    addr_t a;
    size_t sz;
    sz = size_t'($urandom_range(2, 0));
    a  = addr_t'($urandom_range(4 * MEM_WORDS - 1, 0));
    if (high) a = a + addr_t'(4 * MEM_WORDS);
    a = a & ~((addr_t'(1) << sz) - addr_t'(1));
    do_load(a, sz, 1'($urandom_range(1, 0)));
  endtask

  task automatic end_test(string name);
    $display("test %0d %s: %0d errors", test_cnt + 1, name, err_cnt - err_base);
    err_base = err_cnt;
    test_cnt++;
  endtask

  initial begin
    int start_cnt;
    void'($urandom(43));
    $readmemh("mem_init.hex", ref_mem);
    rstn           <= 1'b1;
    redirect_valid <= 1'b0;
    redirect_pc    <= '0;
    instr_ready    <= 1'b0;
    load_valid     <= 1'b0;
    load_addr      <= '0;
    load_size      <= '0;
    load_signed    <= 1'b0;
    repeat (3) @(posedge clk);
    rstn <= 1'b0;

    instr_ready <= 1'b1;
    wait_fetches(N_SEQ);
    end_test("sequential fetch");

    for (int i = 0; i < N_REDIR; i++) begin
      repeat ($urandom_range(3, 0)) @(posedge clk);  // hit the fetch at varying phases
      redirect_to(addr_t'($urandom_range(MEM_WORDS - 1, 0)) << 2);
      wait_fetches(4);
    end
    end_test("redirect");

    instr_ready <= 1'b0;  // fetch stalls so loads mostly run alone
    for (int i = 0; i < N_LOAD; i++) random_load(1'b0);
    end_test("loads");

    instr_ready <= 1'b1;
    for (int i = 0; i < N_CONT; i++) begin
      repeat ($urandom_range(3, 0)) @(posedge clk);
      random_load(1'b0);
    end
    end_test("contention");

    redirect_to(addr_t'(32'h40));
    start_cnt = fetch_cnt;
    while (fetch_cnt < start_cnt + N_BP) begin
      instr_ready <= 1'b0;
      repeat ($urandom_range(MAX_STALL, 1)) @(posedge clk);
      instr_ready <= 1'b1;
      @(posedge clk);
    end
    end_test("back-pressure");

    for (int i = 0; i < N_ERR; i++) random_load(1'b1);
    redirect_to(addr_t'(4 * MEM_WORDS) + (addr_t'($urandom_range(15, 0)) << 2));
    wait_fetches(N_ERR);
    end_test("error response");

    $display("tests %0d, fetches %0d, loads %0d, errors %0d",
             test_cnt, fetch_cnt, load_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d cycles", LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: mem_init.hex
// ram contents, four 32-bit words per line, line n holds word addresses 4n to 4n+3
0000FF03 0304FE07 0608FD0B 090CFC0F
0C10FB13 0F14FA17 1218F91B 151CF81F
1820F723 1B24F627 1E28F52B 212CF42F
2430F333 2734F237 2A38F13B 2D3CF03F
3040EF43 3344EE47 3648ED4B 394CEC4F
3C50EB53 3F54EA57 4258E95B 455CE85F
4860E763 4B64E667 4E68E56B 516CE46F
5470E373 5774E277 5A78E17B 5D7CE07F
6080DF83 6384DE87 6688DD8B 698CDC8F
6C90DB93 6F94DA97 7298D99B 759CD89F
78A0D7A3 7BA4D6A7 7EA8D5AB 81ACD4AF
84B0D3B3 87B4D2B7 8AB8D1BB 8DBCD0BF
90C0CFC3 93C4CEC7 96C8CDCB 99CCCCCF
9CD0CBD3 9FD4CAD7 A2D8C9DB A5DCC8DF
A8E0C7E3 ABE4C6E7 AEE8C5EB B1ECC4EF
B4F0C3F3 B7F4C2F7 BAF8C1FB BDFCC0FF

// File: build.f
verilog/mem_pkg.sv
verilog/mem_arb.sv
verilog/ifu_fetch.sv
verilog/lsu_load.sv
verilog/sram_rd.sv
verilog/mem_sys.sv
tb/tb_mem_sys.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with verilator, then check the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_sys -f build.f \
  && ./obj_dir/Vtb_mem_sys 2>&1 | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
